//--- hdl/access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module access_fsm #(
    parameter int RAM_LATENCY = 3
) (
    input  logic               clk,
    input  logic               reset,
    cpu_bus_if.consumer        bus,
    input  logic               local_hit,
    input  msx_pkg::byte_t     local_data,
    input  logic               write_blocked,
    input  logic               empty,
    input  msx_pkg::ram_addr_t ram_addr_in,  // From mapper, strobe cycle
    input  msx_pkg::byte_t     ram_dout,
    input  logic               timer_expired,
    output logic               timer_start,
    output msx_pkg::ram_addr_t ram_addr,
    output msx_pkg::byte_t     ram_din,
    output logic               ram_rnw,
    output logic               ram_ce,
    output msx_pkg::byte_t     data,
    output logic               done,
    output logic               busy
);

    localparam bit ZERO_WAIT = (RAM_LATENCY == 0);  // Data already valid with ram_ce

    msx_pkg::access_state_t state_q;
    msx_pkg::ram_addr_t     ram_addr_q;
    msx_pkg::byte_t         ram_din_q;
    logic                   ram_rnw_q;
    msx_pkg::byte_t         data_q;
    msx_pkg::byte_t         quick_data;
    logic                   strobe;
    logic                   needs_ram;
    logic                   rd_strobe;
    logic                   capture;

    assign strobe    = bus.mem_rd || bus.mem_wr || bus.io_rd || bus.io_wr;
    assign rd_strobe = bus.mem_rd || bus.io_rd;

    // Only memory accesses to a mapped, writable block go out
    assign needs_ram = !local_hit && !empty
                    && (bus.mem_rd || (bus.mem_wr && !write_blocked));

    assign timer_start = (state_q == msx_pkg::st_idle) && needs_ram;

    assign quick_data = local_hit ? local_data : 8'hFF;  // Open bus reads FFh

    assign capture = ram_rnw_q
                  && (((state_q == msx_pkg::st_wait) && timer_expired)
                  ||  ((state_q == msx_pkg::st_issue) && ZERO_WAIT));

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= msx_pkg::st_idle;
            ram_rnw_q <= 1'b1;
        end else begin
            case (state_q)
                msx_pkg::st_idle: begin
                    if (needs_ram) begin   // Strobes while busy never seen here
                        state_q   <= msx_pkg::st_issue;
                        ram_rnw_q <= bus.mem_rd;
                    end else if (strobe) begin
                        state_q <= msx_pkg::st_done;
                    end
                end
                msx_pkg::st_issue: state_q <= ZERO_WAIT ? msx_pkg::st_done : msx_pkg::st_wait;
                msx_pkg::st_wait: begin
                    if (timer_expired) begin
                        state_q <= msx_pkg::st_done;
                    end
                end
                default: state_q <= msx_pkg::st_idle;  // st_done
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == msx_pkg::st_idle) && needs_ram) begin
            ram_addr_q <= ram_addr_in;   // Held for the whole access
            ram_din_q  <= bus.wdata;
        end
        if ((state_q == msx_pkg::st_idle) && rd_strobe && !needs_ram) begin
            data_q <= quick_data;
        end else if (capture) begin
            data_q <= ram_dout;
        end
    end

    assign ram_addr = ram_addr_q;
    assign ram_din  = ram_din_q;
    assign ram_rnw  = ram_rnw_q;
    assign ram_ce   = state_q == msx_pkg::st_issue;  // Single cycle
    assign data     = data_q;
    assign done     = state_q == msx_pkg::st_done;
    assign busy     = state_q != msx_pkg::st_idle;

endmodule

`default_nettype wire

//--- hdl/ascii8_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module ascii8_mapper (
    input  logic               clk,
    input  logic               reset,
    cpu_bus_if.consumer        bus,
    input  msx_pkg::block_t    block,          // Active block
    output msx_pkg::ram_addr_t ram_addr,       // Physical address
    output logic               write_blocked,  // Write must not reach RAM
    output logic               empty           // Nothing mapped here
);

    msx_pkg::bank_t     bank_q [4];  // 8K windows at 4000h, 6000h, 8000h, A000h
    logic [1:0]         win;
    logic               bank_wr;
    msx_pkg::ram_addr_t offset;

    // Window number inside pages 1 and 2
    assign win = {bus.addr[15], bus.addr[13]};

    // Bank registers live at 6000h-7FFFh, bits 12:11 pick one
    assign bank_wr = bus.mem_wr
                  && (block.kind == msx_pkg::blk_ascii8)
                  && (bus.addr[15:13] == 3'b011);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= msx_pkg::bank_t'(i);  // Linear 32K at power up
            end
        end else if (bank_wr) begin
            bank_q[bus.addr[12:11]] <= bus.wdata;
        end
    end

    always_comb begin
        case (block.kind)
            msx_pkg::blk_ascii8: begin
                // Bank times 8K plus offset in window
                offset = msx_pkg::ram_addr_t'({bank_q[win], bus.addr[12:0]});
            end
            default: begin
                offset = msx_pkg::ram_addr_t'(bus.addr[13:0]);  // 16K linear
            end
        endcase
    end

    assign ram_addr = block.base + offset;

    // ROM and mapper space never written, RAM only if not protected
    assign write_blocked = (block.kind == msx_pkg::blk_rom)
                        || (block.kind == msx_pkg::blk_ascii8)
                        || ((block.kind == msx_pkg::blk_ram) && block.ro);

    assign empty = block.kind == msx_pkg::blk_empty;

endmodule

`default_nettype wire

//--- hdl/block_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module block_decoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_we,     // Layout table write
    input  msx_pkg::layout_idx_t cfg_index,  // Entry to load
    input  msx_pkg::block_t      cfg_block,  // Entry contents
    input  msx_pkg::slot_t       slot,
    input  msx_pkg::slot_t       subslot,
    input  msx_pkg::page_t       page,
    output msx_pkg::block_t      block       // Active block for this access
);

    msx_pkg::block_t      layout_q [64];
    msx_pkg::layout_idx_t idx;

    // Same ordering as the configuration index
    assign idx = {slot, subslot, page};

    always_ff @(posedge clk) begin
        if (reset) begin
            // Whole map reads as unpopulated
            for (int i = 0; i < 64; i++) begin
                layout_q[i] <= '{kind: msx_pkg::blk_empty, ro: 1'b0, base: '0};
            end
        end else if (cfg_we) begin
            layout_q[cfg_index] <= cfg_block;
        end
    end

    // Lookup is combinational, follows addr directly
    assign block = layout_q[idx];

endmodule

`default_nettype wire

//--- hdl/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded Z80 strobes, one-cycle pulses
interface cpu_bus_if;

    msx_pkg::cpu_addr_t addr;   // Memory or I/O address
    msx_pkg::byte_t     wdata;  // Write data
    logic               mem_rd; // Memory read
    logic               mem_wr; // Memory write
    logic               io_rd;  // I/O read
    logic               io_wr;  // I/O write

    modport producer (
        output addr,
        output wdata,
        output mem_rd,
        output mem_wr,
        output io_rd,
        output io_wr
    );

    modport consumer (
        input addr,
        input wdata,
        input mem_rd,
        input mem_wr,
        input io_rd,
        input io_wr
    );

endinterface

`default_nettype wire

//--- hdl/msx_pkg.sv
`default_nettype none

package msx_pkg;

    typedef logic [15:0] cpu_addr_t;    // Z80 address
    typedef logic [7:0]  byte_t;        // Data byte
    typedef logic [26:0] ram_addr_t;    // External RAM address
    typedef logic [1:0]  slot_t;        // Primary slot or subslot number
    typedef logic [1:0]  page_t;        // 16K page, addr[15:14]
    typedef logic [5:0]  layout_idx_t;  // {slot, subslot, page}

    // ASCII8 bank number
    localparam int ASCII8_BANK_BITS = 8;
    typedef logic [ASCII8_BANK_BITS-1:0] bank_t;

    // What sits behind a layout entry
    typedef enum logic [1:0] {
        blk_empty,
        blk_rom,
        blk_ram,
        blk_ascii8
    } block_kind_t;

    // One layout table entry
    typedef struct packed {
        block_kind_t kind;  // Block type
        logic        ro;    // Write protect for RAM blocks
        ram_addr_t   base;  // Start of the block in external RAM
    } block_t;

    // Access sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait,
        st_done
    } access_state_t;

endpackage

`default_nettype wire

//--- hdl/msx_slots.sv
`timescale 1ns/1ps
`default_nettype none

module msx_slots #(
    parameter int RAM_LATENCY = 3  // RAM cycles from ram_ce to ram_dout
) (
    input  logic                 clk,
    input  logic                 reset,
    input  msx_pkg::cpu_addr_t   addr,
    input  msx_pkg::byte_t       wdata,
    input  logic                 mem_rd,
    input  logic                 mem_wr,
    input  logic                 io_rd,
    input  logic                 io_wr,
    input  logic [3:0]           slot_expanded,
    input  logic                 cfg_we,
    input  msx_pkg::layout_idx_t cfg_index,
    input  msx_pkg::block_t      cfg_block,
    output msx_pkg::ram_addr_t   ram_addr,
    output msx_pkg::byte_t       ram_din,
    input  msx_pkg::byte_t       ram_dout,
    output logic                 ram_rnw,
    output logic                 ram_ce,
    output msx_pkg::byte_t       data,
    output logic                 done,
    output logic                 busy
);

    cpu_bus_if bus ();

    msx_pkg::slot_t     slot;
    msx_pkg::slot_t     subslot;
    msx_pkg::page_t     page;
    logic               local_hit;
    msx_pkg::byte_t     local_data;
    msx_pkg::block_t    block;
    msx_pkg::ram_addr_t mapped_addr;
    logic               write_blocked;
    logic               empty;
    logic               timer_start;
    logic               timer_expired;

    // CPU pins onto the internal bus
    assign bus.addr   = addr;
    assign bus.wdata  = wdata;
    assign bus.mem_rd = mem_rd;
    assign bus.mem_wr = mem_wr;
    assign bus.io_rd  = io_rd;
    assign bus.io_wr  = io_wr;

    assign page = addr[15:14];

    slot_select u_slot_select (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus),
        .slot_expanded (slot_expanded),
        .slot          (slot),
        .subslot       (subslot),
        .local_hit     (local_hit),
        .local_data    (local_data)
    );

    block_decoder u_block_decoder (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_index (cfg_index),
        .cfg_block (cfg_block),
        .slot      (slot),
        .subslot   (subslot),
        .page      (page),
        .block     (block)
    );

    ascii8_mapper u_ascii8_mapper (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus),
        .block         (block),
        .ram_addr      (mapped_addr),
        .write_blocked (write_blocked),
        .empty         (empty)
    );

    wait_timer #(.RAM_LATENCY(RAM_LATENCY)) u_wait_timer (
        .clk     (clk),
        .reset   (reset),
        .start   (timer_start),
        .expired (timer_expired)
    );

    access_fsm #(.RAM_LATENCY(RAM_LATENCY)) u_access_fsm (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus),
        .local_hit     (local_hit),
        .local_data    (local_data),
        .write_blocked (write_blocked),
        .empty         (empty),
        .ram_addr_in   (mapped_addr),
        .ram_dout      (ram_dout),
        .timer_expired (timer_expired),
        .timer_start   (timer_start),
        .ram_addr      (ram_addr),
        .ram_din       (ram_din),
        .ram_rnw       (ram_rnw),
        .ram_ce        (ram_ce),
        .data          (data),
        .done          (done),
        .busy          (busy)
    );

endmodule

`default_nettype wire

//--- hdl/slot_select.sv
`timescale 1ns/1ps
`default_nettype none

module slot_select (
    input  logic           clk,
    input  logic           reset,
    cpu_bus_if.consumer    bus,
    input  logic [3:0]     slot_expanded,  // One bit per primary slot
    output msx_pkg::slot_t slot,           // Primary slot of addressed page
    output msx_pkg::slot_t subslot,        // Subslot of addressed page
    output logic           local_hit,      // A8h or FFFFh owned here
    output msx_pkg::byte_t local_data      // Read data for local hits
);

    msx_pkg::byte_t primary_q;       // Port A8h, 2 bits per page
    msx_pkg::byte_t subslot_q [4];   // FFFFh register per primary slot
    msx_pkg::page_t page;
    logic           expanded;
    logic           io_a8;
    logic           sub_reg;
    logic           io_acc;
    logic           mem_acc;

    assign page    = bus.addr[15:14];
    assign io_acc  = bus.io_rd || bus.io_wr;
    assign mem_acc = bus.mem_rd || bus.mem_wr;

    // Primary slot for the page under the address
    assign slot     = primary_q[{page, 1'b0} +: 2];
    assign expanded = slot_expanded[slot];

    // Unexpanded slots always report subslot 0
    assign subslot = expanded ? subslot_q[slot][{page, 1'b0} +: 2] : '0;

    assign io_a8   = bus.addr[7:0] == 8'hA8;            // Only low byte decoded on I/O
    assign sub_reg = expanded && (bus.addr == 16'hFFFF); // Page 3 slot, since addr is FFFFh

    assign local_hit = (io_a8 && io_acc) || (sub_reg && mem_acc);

    // Subslot register reads back inverted
    assign local_data = io_acc ? primary_q : ~subslot_q[slot];

    always_ff @(posedge clk) begin
        if (reset) begin
            primary_q <= '0;
            for (int i = 0; i < 4; i++) begin
                subslot_q[i] <= '0;
            end
        end else begin
            if (bus.io_wr && io_a8) begin
                primary_q <= bus.wdata;
            end
            if (bus.mem_wr && sub_reg) begin
                subslot_q[slot] <= bus.wdata;  // Goes to the slot seen in page 3
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/wait_timer.sv
`timescale 1ns/1ps
`default_nettype none

module wait_timer #(
    parameter int RAM_LATENCY = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic start,    // Same cycle as the CPU strobe
    output logic expired   // RAM data valid now
);

    localparam int CNT_W = $clog2(RAM_LATENCY + 2);

    logic [CNT_W-1:0] count_q;
    logic             active_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q  <= '0;
            active_q <= 1'b0;
        end else if (start) begin
            count_q  <= CNT_W'(RAM_LATENCY);
            active_q <= 1'b1;
        end else if (active_q) begin
            if (count_q == '0) begin
                active_q <= 1'b0;       // Single expired pulse
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign expired = active_q && (count_q == '0);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_msx_slots -o sim_msx_slots || exit 1
out=$(./obj_dir/sim_msx_slots +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1

//--- sim.f
hdl/msx_pkg.sv
hdl/cpu_bus_if.sv
hdl/slot_select.sv
hdl/block_decoder.sv
hdl/ascii8_mapper.sv
hdl/wait_timer.sv
hdl/access_fsm.sv
hdl/msx_slots.sv
tb/slots_checker.sv
tb/slots_monitor.sv
tb/tb_msx_slots.sv

//--- tb/slots_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Bus protocol assertions, bound into msx_slots
module slots_checker (
    input logic clk,
    input logic reset,
    input logic mem_rd,
    input logic mem_wr,
    input logic io_rd,
    input logic io_wr,
    input logic ram_ce,
    input logic done,
    input logic busy
);

    logic strobe;
    int   ce_fail     = 0;  // Failure count per property
    int   busy_fail   = 0;
    int   strobe_fail = 0;
    int   reset_fail  = 0;
    int   fail_count;       // Read by the testbench at the end

    assign strobe     = mem_rd || mem_wr || io_rd || io_wr;
    assign fail_count = ce_fail + busy_fail + strobe_fail + reset_fail;

    // RAM enable is a single-cycle pulse
    ce_single: assert property (@(posedge clk) disable iff (reset) ram_ce |=> !ram_ce)
        else begin
            $error("ram_ce held for more than one cycle");
            ce_fail++;
        end

    done_in_busy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
        else begin
            $error("done high while busy is low");
            busy_fail++;
        end

    // CPU must stall on busy
    strobe_idle: assert property (@(posedge clk) disable iff (reset) strobe |-> !busy)
        else begin
            $error("CPU strobe while busy");
            strobe_fail++;
        end

    ce_in_reset: assert property (@(posedge clk) reset |=> !ram_ce)
        else begin
            $error("ram_ce active around reset");
            reset_fail++;
        end

endmodule

bind msx_slots slots_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .io_rd  (io_rd),
    .io_wr  (io_wr),
    .ram_ce (ram_ce),
    .done   (done),
    .busy   (busy)
);

`default_nettype wire

//--- tb/slots_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module slots_monitor #(
    parameter int RAM_LATENCY = 3
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_rd,
    input  logic               mem_wr,
    input  logic               io_rd,
    input  logic               io_wr,
    input  logic               ram_ce,
    input  msx_pkg::ram_addr_t ram_addr,
    input  logic               done,
    input  logic               busy,
    input  msx_pkg::byte_t     data,
    input  int                 test_id,       // Current table entry
    input  msx_pkg::byte_t     exp_data,      // Read data, reads only
    input  logic               exp_ram,       // Access must reach RAM
    input  msx_pkg::ram_addr_t exp_ram_addr,
    output int                 test_count,
    output int                 error_count
);

    int                 cycles;     // Edges since the strobe
    int                 ce_count;
    int                 errs_now;   // Mismatches in current test
    logic               active;
    logic               is_read;
    logic               busy_gap;
    msx_pkg::ram_addr_t ce_addr;    // Address seen with ram_ce

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: test %0d %s", $time, test_id, msg);
        errs_now++;
        error_count++;
    endtask

    task automatic check_result();
        int    exp_cycles;
        int    exp_ce;
        string verdict;
        exp_cycles = exp_ram ? RAM_LATENCY + 2 : 1;
        exp_ce     = exp_ram ? 1 : 0;
        errs_now   = 0;
        if (cycles != exp_cycles) begin
            report_error($sformatf("done after %0d cycles, expected %0d", cycles, exp_cycles));
        end
        if (ce_count != exp_ce) begin
            report_error($sformatf("%0d ram_ce pulses, expected %0d", ce_count, exp_ce));
        end
        if (exp_ram && (ce_count == 1) && (ce_addr !== exp_ram_addr)) begin
            report_error($sformatf("ram_addr %h, expected %h", ce_addr, exp_ram_addr));
        end
        if (is_read && (data !== exp_data)) begin
            report_error($sformatf("data %h, expected %h", data, exp_data));
        end
        if (busy_gap) begin
            report_error("busy dropped before done");
        end
        if (errs_now == 0) begin
            verdict = "ok";
        end else begin
            verdict = "mismatch";
        end
        test_count++;
        $display("test %0d %s: done after %0d cycles, %0d ram_ce", test_id, verdict,
                 cycles, ce_count);
    endtask

    // Sampled on the rising edge, inputs settle 1 ns after it
    always @(posedge clk) begin
        if (reset) begin
            active      = 1'b0;
            test_count  = 0;
            error_count = 0;
        end else if (active) begin
            cycles++;
            if (ram_ce) begin
                ce_count++;
                ce_addr = ram_addr;
            end
            if (!busy) begin
                busy_gap = 1'b1;  // Whole span must be covered
            end
            if (done) begin
                check_result();
                active = 1'b0;
            end
        end else if (mem_rd || mem_wr || io_rd || io_wr) begin
            active   = 1'b1;
            cycles   = 0;
            ce_count = 0;
            busy_gap = 1'b0;
            is_read  = mem_rd || io_rd;
        end
    end

    task automatic report_counts();
        $display("%0d tests run, %0d mismatches", test_count, error_count);
    endtask

endmodule

`default_nettype wire

//--- tb/tb_msx_slots.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_slots;

    localparam int RAM_LATENCY  = 3;
    localparam int RESET_CYCLES = 10;
    localparam int CFG_CYCLES   = 12;  // Layout writes plus margin

    localparam logic [1:0] OP_MRD = 2'd0;
    localparam logic [1:0] OP_MWR = 2'd1;
    localparam logic [1:0] OP_IRD = 2'd2;
    localparam logic [1:0] OP_IWR = 2'd3;

    // One stimulus table row
    typedef struct packed {
        logic [1:0]         op;
        msx_pkg::cpu_addr_t addr;
        msx_pkg::byte_t     wdata;
        msx_pkg::byte_t     exp_data;
        logic               ram;       // Expect one RAM access
        msx_pkg::ram_addr_t ram_addr;
    } test_t;

    logic                 clk;
    logic                 reset;
    msx_pkg::cpu_addr_t   addr;
    msx_pkg::byte_t       wdata;
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 io_rd;
    logic                 io_wr;
    logic [3:0]           slot_expanded;
    logic                 cfg_we;
    msx_pkg::layout_idx_t cfg_index;
    msx_pkg::block_t      cfg_block;
    msx_pkg::ram_addr_t   ram_addr;
    msx_pkg::byte_t       ram_din;
    msx_pkg::byte_t       ram_dout;
    logic                 ram_rnw;
    logic                 ram_ce;
    msx_pkg::byte_t       data;
    logic                 done;
    logic                 busy;

    int                 test_id;
    msx_pkg::byte_t     exp_data;
    logic               exp_ram;
    msx_pkg::ram_addr_t exp_ram_addr;
    int                 test_count;
    int                 error_count;
    logic               table_ready;
    test_t              tests [$];

    // Sparse RAM, untouched bytes follow a fill pattern
    msx_pkg::byte_t ram_mem [msx_pkg::ram_addr_t];
    msx_pkg::byte_t rd_q    = 8'h00;
    int             lat_cnt = 0;

    msx_slots #(.RAM_LATENCY(RAM_LATENCY)) i_dut (
        .clk           (clk),
        .reset         (reset),
        .addr          (addr),
        .wdata         (wdata),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr),
        .io_rd         (io_rd),
        .io_wr         (io_wr),
        .slot_expanded (slot_expanded),
        .cfg_we        (cfg_we),
        .cfg_index     (cfg_index),
        .cfg_block     (cfg_block),
        .ram_addr      (ram_addr),
        .ram_din       (ram_din),
        .ram_dout      (ram_dout),
        .ram_rnw       (ram_rnw),
        .ram_ce        (ram_ce),
        .data          (data),
        .done          (done),
        .busy          (busy)
    );

    slots_monitor #(.RAM_LATENCY(RAM_LATENCY)) u_monitor (
        .clk          (clk),
        .reset        (reset),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .io_rd        (io_rd),
        .io_wr        (io_wr),
        .ram_ce       (ram_ce),
        .ram_addr     (ram_addr),
        .done         (done),
        .busy         (busy),
        .data         (data),
        .test_id      (test_id),
        .exp_data     (exp_data),
        .exp_ram      (exp_ram),
        .exp_ram_addr (exp_ram_addr),
        .test_count   (test_count),
        .error_count  (error_count)
    );

    function automatic msx_pkg::byte_t fill_byte(input msx_pkg::ram_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'd0, a[26:24]} ^ 8'h5A;
    endfunction

    function automatic msx_pkg::byte_t ram_read(input msx_pkg::ram_addr_t a);
        if (ram_mem.exists(a)) begin
            return ram_mem[a];
        end
        return fill_byte(a);
    endfunction

    // Cartridge base plus bank times 8K plus window offset
    function automatic msx_pkg::ram_addr_t ascii8_addr(input msx_pkg::byte_t bank,
                                                       input logic [12:0] off);
        return 27'h100000 + msx_pkg::ram_addr_t'(bank) * 27'h2000 + msx_pkg::ram_addr_t'(off);
    endfunction

    // Read data shows up RAM_LATENCY edges after ram_ce
    always @(posedge clk) begin
        if (ram_ce) begin
            lat_cnt <= RAM_LATENCY;
            if (ram_rnw) begin
                rd_q <= ram_read(ram_addr);
            end else begin
                ram_mem[ram_addr] = ram_din;
            end
        end else if (lat_cnt != 0) begin
            lat_cnt <= lat_cnt - 1;
        end
    end

    assign ram_dout = (lat_cnt == 1) ? rd_q : 8'hEE;  // Junk outside the valid cycle

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_test(input logic [1:0] op, input msx_pkg::cpu_addr_t a,
                            input msx_pkg::byte_t wd, input msx_pkg::byte_t exp_d,
                            input logic ram, input msx_pkg::ram_addr_t ra);
        test_t t;
        t.op       = op;
        t.addr     = a;
        t.wdata    = wd;
        t.exp_data = exp_d;
        t.ram      = ram;
        t.ram_addr = ra;
        tests.push_back(t);
    endtask

    task automatic write_layout(input msx_pkg::slot_t s, input msx_pkg::slot_t sub,
                                input msx_pkg::page_t p, input msx_pkg::block_kind_t kind,
                                input logic ro, input msx_pkg::ram_addr_t base);
        cfg_we         = 1'b1;
        cfg_index      = {s, sub, p};
        cfg_block.kind = kind;
        cfg_block.ro   = ro;
        cfg_block.base = base;
        @(posedge clk);
        #1;
    endtask

    task automatic build_table();
        add_test(OP_IRD, 16'h00A8, 8'h00, 8'h00, 1'b0, 27'h0);  // Primary reg after reset
        add_test(OP_MRD, 16'h8000, 8'h00, 8'hFF, 1'b0, 27'h0);  // Empty page 2
        add_test(OP_MWR, 16'h8000, 8'h12, 8'h00, 1'b0, 27'h0);
        add_test(OP_MRD, 16'h0123, 8'h00, fill_byte(27'h000123), 1'b1, 27'h000123);
        add_test(OP_MRD, 16'h5ABC, 8'h00, fill_byte(27'h005ABC), 1'b1, 27'h005ABC);
        add_test(OP_MWR, 16'h0123, 8'h77, 8'h00, 1'b0, 27'h0);  // ROM write dropped
        add_test(OP_MRD, 16'h0123, 8'h00, fill_byte(27'h000123), 1'b1, 27'h000123);
        // Pages 0..3 to slots 0..3
        add_test(OP_IWR, 16'h00A8, 8'hE4, 8'h00, 1'b0, 27'h0);
        add_test(OP_IRD, 16'h00A8, 8'h00, 8'hE4, 1'b0, 27'h0);
        add_test(OP_MWR, 16'hC010, 8'h3C, 8'h00, 1'b1, 27'h010010);
        add_test(OP_MRD, 16'hC010, 8'h00, 8'h3C, 1'b1, 27'h010010);
        add_test(OP_MWR, 16'hFFFF, 8'h55, 8'h00, 1'b1, 27'h013FFF);  // Slot 3 not expanded
        add_test(OP_MRD, 16'hFFFF, 8'h00, 8'h55, 1'b1, 27'h013FFF);
        add_test(OP_MRD, 16'h8100, 8'h00, fill_byte(27'h044100), 1'b1, 27'h044100);
        // Page 3 to expanded slot 2, then subslot 1 in pages 2 and 3
        add_test(OP_IWR, 16'h00A8, 8'hA4, 8'h00, 1'b0, 27'h0);
        add_test(OP_MWR, 16'hFFFF, 8'h50, 8'h00, 1'b0, 27'h0);
        add_test(OP_MRD, 16'hFFFF, 8'h00, 8'hAF, 1'b0, 27'h0);
        add_test(OP_MRD, 16'h8100, 8'h00, fill_byte(27'h040100), 1'b1, 27'h040100);
        add_test(OP_MRD, 16'hC200, 8'h00, fill_byte(27'h034200), 1'b1, 27'h034200);
        add_test(OP_MWR, 16'hC200, 8'h99, 8'h00, 1'b0, 27'h0);  // Read-only RAM
        add_test(OP_MRD, 16'hC200, 8'h00, fill_byte(27'h034200), 1'b1, 27'h034200);
        add_test(OP_MWR, 16'hFFFF, 8'h00, 8'h00, 1'b0, 27'h0);
        add_test(OP_MRD, 16'hFFFF, 8'h00, 8'hFF, 1'b0, 27'h0);
        add_test(OP_MWR, 16'hC200, 8'h42, 8'h00, 1'b1, 27'h030200);
        add_test(OP_MRD, 16'hC200, 8'h00, 8'h42, 1'b1, 27'h030200);
        // ASCII8 cartridge in pages 1 and 2
        add_test(OP_IWR, 16'h00A8, 8'hD4, 8'h00, 1'b0, 27'h0);
        add_test(OP_MRD, 16'hC010, 8'h00, 8'h3C, 1'b1, 27'h010010);
        add_test(OP_MRD, 16'h4010, 8'h00, fill_byte(ascii8_addr(8'h00, 13'h0010)), 1'b1,
                 ascii8_addr(8'h00, 13'h0010));
        add_test(OP_MRD, 16'h6020, 8'h00, fill_byte(ascii8_addr(8'h01, 13'h0020)), 1'b1,
                 ascii8_addr(8'h01, 13'h0020));
        add_test(OP_MRD, 16'h8030, 8'h00, fill_byte(ascii8_addr(8'h02, 13'h0030)), 1'b1,
                 ascii8_addr(8'h02, 13'h0030));
        add_test(OP_MRD, 16'hA040, 8'h00, fill_byte(ascii8_addr(8'h03, 13'h0040)), 1'b1,
                 ascii8_addr(8'h03, 13'h0040));
        add_test(OP_MWR, 16'h6000, 8'h10, 8'h00, 1'b0, 27'h0);  // Bank registers
        add_test(OP_MWR, 16'h6800, 8'h21, 8'h00, 1'b0, 27'h0);
        add_test(OP_MWR, 16'h7000, 8'h32, 8'h00, 1'b0, 27'h0);
        add_test(OP_MWR, 16'h7800, 8'h43, 8'h00, 1'b0, 27'h0);
        add_test(OP_MRD, 16'h4010, 8'h00, fill_byte(ascii8_addr(8'h10, 13'h0010)), 1'b1,
                 ascii8_addr(8'h10, 13'h0010));
        add_test(OP_MRD, 16'h6020, 8'h00, fill_byte(ascii8_addr(8'h21, 13'h0020)), 1'b1,
                 ascii8_addr(8'h21, 13'h0020));
        add_test(OP_MRD, 16'h8030, 8'h00, fill_byte(ascii8_addr(8'h32, 13'h0030)), 1'b1,
                 ascii8_addr(8'h32, 13'h0030));
        add_test(OP_MRD, 16'hA040, 8'h00, fill_byte(ascii8_addr(8'h43, 13'h0040)), 1'b1,
                 ascii8_addr(8'h43, 13'h0040));
    endtask

    initial begin
        test_t t;
        reset         = 1'b1;
        addr          = '0;
        wdata         = '0;
        mem_rd        = 1'b0;
        mem_wr        = 1'b0;
        io_rd         = 1'b0;
        io_wr         = 1'b0;
        slot_expanded = 4'b0100;  // Only slot 2 has subslots
        cfg_we        = 1'b0;
        cfg_index     = '0;
        cfg_block     = '0;
        test_id       = 0;
        exp_data      = '0;
        exp_ram       = 1'b0;
        exp_ram_addr  = '0;
        table_ready   = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        write_layout(2'd0, 2'd0, 2'd0, msx_pkg::blk_rom, 1'b0, 27'h000000);
        write_layout(2'd0, 2'd0, 2'd1, msx_pkg::blk_rom, 1'b0, 27'h004000);
        write_layout(2'd1, 2'd0, 2'd1, msx_pkg::blk_ascii8, 1'b0, 27'h100000);
        write_layout(2'd1, 2'd0, 2'd2, msx_pkg::blk_ascii8, 1'b0, 27'h100000);
        write_layout(2'd3, 2'd0, 2'd3, msx_pkg::blk_ram, 1'b0, 27'h010000);
        write_layout(2'd2, 2'd0, 2'd2, msx_pkg::blk_ram, 1'b0, 27'h044000);
        write_layout(2'd2, 2'd1, 2'd2, msx_pkg::blk_rom, 1'b0, 27'h040000);
        write_layout(2'd2, 2'd0, 2'd3, msx_pkg::blk_ram, 1'b0, 27'h030000);
        write_layout(2'd2, 2'd1, 2'd3, msx_pkg::blk_ram, 1'b1, 27'h034000);
        cfg_we = 1'b0;
        @(posedge clk);
        #1;
        for (int i = 0; i < tests.size(); i++) begin
            t            = tests[i];
            test_id      = i;
            addr         = t.addr;
            wdata        = t.wdata;
            exp_data     = t.exp_data;
            exp_ram      = t.ram;
            exp_ram_addr = t.ram_addr;
            case (t.op)
                OP_MRD:  mem_rd = 1'b1;
                OP_MWR:  mem_wr = 1'b1;
                OP_IRD:  io_rd  = 1'b1;
                default: io_wr  = 1'b1;
            endcase
            @(posedge clk);
            #1;
            mem_rd = 1'b0;  // One-cycle strobe
            mem_wr = 1'b0;
            io_rd  = 1'b0;
            io_wr  = 1'b0;
            while (!done) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);  // Let the done cycle end
            #1;
        end
        repeat (2) @(posedge clk);
        u_monitor.report_counts();
        if ((error_count == 0) && (test_count == tests.size())
                && (i_dut.u_checker.fail_count == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (tests.size() * (RAM_LATENCY + 6) + RESET_CYCLES + CFG_CYCLES) @(posedge clk);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
